// File: include/riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// data and address width
`define RISCV_XLEN 32

// register index width, 32 registers
`define RISCV_REGA_W 5

// data memory size in words
`define RISCV_DMEM_WORDS 256

// first fetch address out of reset
`define RISCV_RESET_PC 32'h0000_0000

`endif

// File: hw/riscv_isa_pkg.sv
package riscv_isa_pkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OP     = 7'b0110011,  // add sub and or xor slt
      OP_IMM = 7'b0010011,  // addi
      LOAD   = 7'b0000011,  // lw
      STORE  = 7'b0100011,  // sw
      BRANCH = 7'b1100011,  // beq bne
      JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      ADD = 3'd0,
      SUB = 3'd1,
      AND = 3'd2,
      OR  = 3'd3,
      XOR = 3'd4,
      SLT = 3'd5   // signed compare
   } alu_op_e;

   // writeback source, 10 marks a load
   typedef enum logic [1:0] {
      ALU = 2'b00,
      PC4 = 2'b01,
      MEM = 2'b10
   } res_src_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;   // imm[11:5]
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;   // imm[4:0]
      logic [6:0] opcode;
   } s_fmt_t;

   // branch offset bits are scattered
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   // one instruction word, five ways to look at it
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      j_fmt_t j;
   } instr_u;

endpackage

// File: hw/riscv_pipe_pkg.sv
`include "riscv_params.svh"

package riscv_pipe_pkg;

   // decoded controls, all zero behaves as a bubble
   typedef struct packed {
      logic                    regwrite;
      logic                    memwrite;
      logic                    branch;
      logic                    branch_ne;   // bne when set, else beq
      logic                    jump;        // jal
      logic                    alusrc_imm;  // operand b from immediate
      riscv_isa_pkg::alu_op_e  alu_op;
      riscv_isa_pkg::res_src_e res_src;
   } ctrl_t;

   typedef struct packed {
      logic                    valid;
      logic [`RISCV_XLEN-1:0]  pc;
      riscv_isa_pkg::instr_u   instr;
   } fd_t;

   typedef struct packed {
      logic                    valid;
      ctrl_t                   ctrl;
      logic [`RISCV_XLEN-1:0]  pc;
      logic [`RISCV_REGA_W-1:0] rs1;
      logic [`RISCV_REGA_W-1:0] rs2;
      logic [`RISCV_REGA_W-1:0] rd;
      logic [`RISCV_XLEN-1:0]  rs1_data;
      logic [`RISCV_XLEN-1:0]  rs2_data;
      logic [`RISCV_XLEN-1:0]  imm;
   } de_t;

   typedef struct packed {
      logic                    valid;
      logic                    regwrite;    // already qualified by valid
      logic                    memwrite;    // same
      riscv_isa_pkg::res_src_e res_src;
      logic [`RISCV_REGA_W-1:0] rd;
      logic [`RISCV_XLEN-1:0]  alu_result;
      logic [`RISCV_XLEN-1:0]  store_data;
      logic [`RISCV_XLEN-1:0]  pc4;
   } em_t;

   typedef struct packed {
      logic                    valid;
      logic                    regwrite;
      logic [`RISCV_REGA_W-1:0] rd;
      logic [`RISCV_XLEN-1:0]  result;
   } mw_t;

   // forward codes: 0 regfile, 1 memory stage, 2 writeback
   typedef struct packed {
      logic [1:0] fwda;
      logic [1:0] fwdb;
      logic       stallpc;
      logic       stallfd;
      logic       flushfd;
      logic       flushde;
   } hz_ctrl_t;

   typedef struct packed {
      logic                    valid;
      logic [`RISCV_REGA_W-1:0] rd;
      logic [`RISCV_XLEN-1:0]  data;
   } retire_t;

endpackage

// File: hw/riscv_hazardunit.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_hazardunit
(
   input  logic [`RISCV_REGA_W-1:0] i_riscv_hzrdu_rs1addr_d,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_hzrdu_rs2addr_d,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_hzrdu_rs1addr_e,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_hzrdu_rs2addr_e,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_hzrdu_rdaddr_e,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_hzrdu_rdaddr_m,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_hzrdu_rdaddr_w,
   input  logic                     i_riscv_hzrdu_regw_m,
   input  logic                     i_riscv_hzrdu_regw_w,
   input  logic                     i_riscv_hzrdu_pcsrc,      // taken branch or jal in execute
   input  riscv_isa_pkg::res_src_e  i_riscv_hzrdu_resultsrc_e,
   output riscv_pipe_pkg::hz_ctrl_t o_riscv_hzrdu_ctrl
);

   logic load_use;   // load in execute feeds the instruction in decode

   // priority pick for one execute operand, memory stage first
   function automatic logic [1:0] fwd_sel
   (
      input logic [`RISCV_REGA_W-1:0] rs,
      input logic [`RISCV_REGA_W-1:0] rd_m,
      input logic                     regw_m,
      input logic [`RISCV_REGA_W-1:0] rd_w,
      input logic                     regw_w
   );
      if (regw_m && rd_m != '0 && rs == rd_m)
      begin
         return 2'd1;   // younger result wins
      end
      else if (regw_w && rd_w != '0 && rs == rd_w)
      begin
         return 2'd2;
      end
      return 2'd0;      // x0 and no match read the regfile
   endfunction

   assign load_use = (i_riscv_hzrdu_resultsrc_e == riscv_isa_pkg::MEM) &&
                     (i_riscv_hzrdu_rs1addr_d == i_riscv_hzrdu_rdaddr_e ||
                      i_riscv_hzrdu_rs2addr_d == i_riscv_hzrdu_rdaddr_e);

   always_comb
   begin
      o_riscv_hzrdu_ctrl.fwda = fwd_sel(i_riscv_hzrdu_rs1addr_e,
                                        i_riscv_hzrdu_rdaddr_m, i_riscv_hzrdu_regw_m,
                                        i_riscv_hzrdu_rdaddr_w, i_riscv_hzrdu_regw_w);
      o_riscv_hzrdu_ctrl.fwdb = fwd_sel(i_riscv_hzrdu_rs2addr_e,
                                        i_riscv_hzrdu_rdaddr_m, i_riscv_hzrdu_regw_m,
                                        i_riscv_hzrdu_rdaddr_w, i_riscv_hzrdu_regw_w);
      // hold pc and fetch/decode one cycle
      o_riscv_hzrdu_ctrl.stallpc = load_use;
      o_riscv_hzrdu_ctrl.stallfd = load_use;
      // redirect kills the two younger slots
      o_riscv_hzrdu_ctrl.flushfd = i_riscv_hzrdu_pcsrc;
      o_riscv_hzrdu_ctrl.flushde = load_use | i_riscv_hzrdu_pcsrc;  // bubble or kill
   end

endmodule

// File: hw/riscv_decode.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_decode
(
   input  riscv_isa_pkg::instr_u     i_instr,
   output riscv_pipe_pkg::ctrl_t     o_ctrl,
   output logic [`RISCV_XLEN-1:0]    o_imm,
   output logic [`RISCV_REGA_W-1:0]  o_rs1,
   output logic [`RISCV_REGA_W-1:0]  o_rs2,
   output logic [`RISCV_REGA_W-1:0]  o_rd
);

   riscv_isa_pkg::opcode_e opcode;
   riscv_isa_pkg::alu_op_e alu_f;    // funct3/funct7 mapping
   logic                   sub_sel;  // only register ops know sub

   assign opcode  = riscv_isa_pkg::opcode_e'(i_instr.r.opcode);
   assign sub_sel = (opcode == riscv_isa_pkg::OP) && i_instr.r.funct7[5];

   // register fields sit at the same bits in every view
   assign o_rs1 = i_instr.r.rs1;
   assign o_rs2 = i_instr.r.rs2;
   assign o_rd  = i_instr.r.rd;

   always_comb
   begin
      case (i_instr.r.funct3)
         3'b000:  alu_f = sub_sel ? riscv_isa_pkg::SUB : riscv_isa_pkg::ADD;
         3'b010:  alu_f = riscv_isa_pkg::SLT;
         3'b100:  alu_f = riscv_isa_pkg::XOR;
         3'b110:  alu_f = riscv_isa_pkg::OR;
         3'b111:  alu_f = riscv_isa_pkg::AND;
         default: alu_f = riscv_isa_pkg::ADD;
      endcase
   end

   always_comb
   begin
      o_ctrl = '0;   // unknown opcode stays a bubble
      o_imm  = '0;
      case (opcode)
         riscv_isa_pkg::OP:
         begin
            o_ctrl.regwrite = 1'b1;
            o_ctrl.alu_op   = alu_f;
         end
         riscv_isa_pkg::OP_IMM:
         begin
            o_ctrl.regwrite   = 1'b1;
            o_ctrl.alusrc_imm = 1'b1;
            o_ctrl.alu_op     = alu_f;
            o_imm = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
         end
         riscv_isa_pkg::LOAD:
         begin
            o_ctrl.regwrite   = 1'b1;
            o_ctrl.alusrc_imm = 1'b1;   // base + offset
            o_ctrl.res_src    = riscv_isa_pkg::MEM;
            o_imm = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
         end
         riscv_isa_pkg::STORE:
         begin
            o_ctrl.memwrite   = 1'b1;
            o_ctrl.alusrc_imm = 1'b1;
            o_imm = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
         end
         riscv_isa_pkg::BRANCH:
         begin
            o_ctrl.branch    = 1'b1;
            o_ctrl.branch_ne = i_instr.b.funct3[0];   // 001 is bne
            o_ctrl.alu_op    = riscv_isa_pkg::SUB;
            o_imm = {{19{i_instr.b.imm12}}, i_instr.b.imm12, i_instr.b.imm11,
                     i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
         end
         riscv_isa_pkg::JAL:
         begin
            o_ctrl.regwrite = 1'b1;
            o_ctrl.jump     = 1'b1;
            o_ctrl.res_src  = riscv_isa_pkg::PC4;    // link value
            o_imm = {{11{i_instr.j.imm20}}, i_instr.j.imm20, i_instr.j.imm19_12,
                     i_instr.j.imm11, i_instr.j.imm10_1, 1'b0};
         end
         default:
         begin
            o_ctrl = '0;
         end
      endcase
   end

endmodule

// File: hw/riscv_regfile.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_regfile
(
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic [`RISCV_REGA_W-1:0] i_rs1,
   input  logic [`RISCV_REGA_W-1:0] i_rs2,
   input  logic                     i_wr_en,
   input  logic [`RISCV_REGA_W-1:0] i_rd,
   input  logic [`RISCV_XLEN-1:0]   i_wr_data,
   output logic [`RISCV_XLEN-1:0]   o_rs1_data,
   output logic [`RISCV_XLEN-1:0]   o_rs2_data
);

   logic [`RISCV_XLEN-1:0] regs [1 << `RISCV_REGA_W];
   logic                   wr_live;   // a real write this cycle

   assign wr_live = i_wr_en && (i_rd != '0);   // x0 never written

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         for (int k = 0; k < (1 << `RISCV_REGA_W); k++)
         begin
            regs[k] <= '0;
         end
      end
      else if (wr_live)
      begin
         regs[i_rd] <= i_wr_data;
      end
   end

   // writeback value seen by decode in the same cycle
   assign o_rs1_data = (wr_live && i_rs1 == i_rd) ? i_wr_data : regs[i_rs1];
   assign o_rs2_data = (wr_live && i_rs2 == i_rd) ? i_wr_data : regs[i_rs2];

endmodule

// File: hw/riscv_execute.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_execute
(
   input  riscv_pipe_pkg::de_t     i_de,
   input  logic [1:0]              i_fwda,
   input  logic [1:0]              i_fwdb,
   input  logic [`RISCV_XLEN-1:0]  i_fwd_m,          // alu result in memory stage
   input  logic [`RISCV_XLEN-1:0]  i_fwd_w,          // writeback result
   output logic [`RISCV_XLEN-1:0]  o_alu_result,
   output logic [`RISCV_XLEN-1:0]  o_store_data,
   output logic [`RISCV_XLEN-1:0]  o_branch_target,
   output logic                    o_pcsrc
);

   logic [`RISCV_XLEN-1:0] src_a;
   logic [`RISCV_XLEN-1:0] reg_b;   // forwarded rs2, before imm select
   logic [`RISCV_XLEN-1:0] src_b;
   logic                   equal;
   logic                   taken;

   always_comb
   begin
      case (i_fwda)
         2'd1:    src_a = i_fwd_m;
         2'd2:    src_a = i_fwd_w;
         default: src_a = i_de.rs1_data;
      endcase
      case (i_fwdb)
         2'd1:    reg_b = i_fwd_m;
         2'd2:    reg_b = i_fwd_w;
         default: reg_b = i_de.rs2_data;
      endcase
   end

   assign src_b        = i_de.ctrl.alusrc_imm ? i_de.imm : reg_b;
   assign o_store_data = reg_b;   // sw data rides with the address

   always_comb
   begin
      case (i_de.ctrl.alu_op)
         riscv_isa_pkg::SUB: o_alu_result = src_a - src_b;
         riscv_isa_pkg::AND: o_alu_result = src_a & src_b;
         riscv_isa_pkg::OR:  o_alu_result = src_a | src_b;
         riscv_isa_pkg::XOR: o_alu_result = src_a ^ src_b;
         riscv_isa_pkg::SLT:
         begin
            o_alu_result = {{(`RISCV_XLEN-1){1'b0}}, ($signed(src_a) < $signed(src_b))};
         end
         default:            o_alu_result = src_a + src_b;   // add, lw/sw address
      endcase
   end

   // beq/bne on the forwarded register operands
   assign equal = (src_a == reg_b);
   assign taken = i_de.ctrl.branch && (i_de.ctrl.branch_ne ? !equal : equal);

   assign o_branch_target = i_de.pc + i_de.imm;   // pc relative for branch and jal
   assign o_pcsrc         = i_de.valid && (i_de.ctrl.jump || taken);

endmodule

// File: hw/riscv_dmem.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_dmem
(
   input  logic                   i_clk,
   input  logic                   i_wr_en,
   input  logic [`RISCV_XLEN-1:0] i_addr,
   input  logic [`RISCV_XLEN-1:0] i_wr_data,
   output logic [`RISCV_XLEN-1:0] o_rd_data
);

   localparam int idx_w = $clog2(`RISCV_DMEM_WORDS);

   logic [`RISCV_XLEN-1:0] mem [`RISCV_DMEM_WORDS];
   logic [idx_w-1:0]       idx;   // word index, byte offset dropped

   assign idx = i_addr[idx_w+1:2];

   always_ff @(posedge i_clk)
   begin
      if (i_wr_en)
      begin
         mem[idx] <= i_wr_data;
      end
   end

   assign o_rd_data = mem[idx];   // lw result in the same cycle

endmodule

// File: hw/riscv_core.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_core
(
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   output logic [`RISCV_XLEN-1:0]  o_imem_addr,
   input  logic [`RISCV_XLEN-1:0]  i_imem_rdata,
   output riscv_pipe_pkg::retire_t o_retire
);

   logic [`RISCV_XLEN-1:0]   pc_q;
   riscv_pipe_pkg::fd_t      fd_q;
   riscv_pipe_pkg::de_t      de_q;
   riscv_pipe_pkg::em_t      em_q;
   riscv_pipe_pkg::mw_t      mw_q;
   riscv_pipe_pkg::hz_ctrl_t hz;

   // decode stage
   riscv_pipe_pkg::ctrl_t    dec_ctrl;
   logic [`RISCV_XLEN-1:0]   dec_imm;
   logic [`RISCV_REGA_W-1:0] dec_rs1;
   logic [`RISCV_REGA_W-1:0] dec_rs2;
   logic [`RISCV_REGA_W-1:0] dec_rd;
   logic [`RISCV_XLEN-1:0]   rs1_data;
   logic [`RISCV_XLEN-1:0]   rs2_data;

   // execute and memory stage
   logic [`RISCV_XLEN-1:0]   ex_alu;
   logic [`RISCV_XLEN-1:0]   ex_store;
   logic [`RISCV_XLEN-1:0]   ex_target;
   logic                     ex_pcsrc;
   logic [`RISCV_XLEN-1:0]   mem_rdata;
   logic [`RISCV_XLEN-1:0]   wb_result;   // selected at the end of memory stage

   assign o_imem_addr = pc_q;

   // pc: stall holds, redirect from execute, else next word
   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         pc_q <= `RISCV_RESET_PC;
      end
      else if (!hz.stallpc)
      begin
         pc_q <= ex_pcsrc ? ex_target : pc_q + 'd4;
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         fd_q.valid <= 1'b0;
      end
      else if (hz.flushfd)
      begin
         fd_q.valid <= 1'b0;   // wrong-path fetch
      end
      else if (!hz.stallfd)
      begin
         fd_q.valid <= 1'b1;
         fd_q.pc    <= pc_q;
         fd_q.instr <= i_imem_rdata;
      end
   end

   riscv_decode riscv_decode_inst
   (
      .i_instr (fd_q.instr),
      .o_ctrl  (dec_ctrl),
      .o_imm   (dec_imm),
      .o_rs1   (dec_rs1),
      .o_rs2   (dec_rs2),
      .o_rd    (dec_rd)
   );

   riscv_regfile riscv_regfile_inst
   (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rs1      (dec_rs1),
      .i_rs2      (dec_rs2),
      .i_wr_en    (mw_q.valid && mw_q.regwrite),
      .i_rd       (mw_q.rd),
      .i_wr_data  (mw_q.result),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data)
   );

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n || hz.flushde)
      begin
         de_q.valid <= 1'b0;   // bubble, controls cleared
         de_q.ctrl  <= '0;
      end
      else
      begin
         de_q.valid    <= fd_q.valid;
         de_q.ctrl     <= fd_q.valid ? dec_ctrl : '0;
         de_q.pc       <= fd_q.pc;
         de_q.rs1      <= dec_rs1;
         de_q.rs2      <= dec_rs2;
         de_q.rd       <= dec_rd;
         de_q.rs1_data <= rs1_data;
         de_q.rs2_data <= rs2_data;
         de_q.imm      <= dec_imm;
      end
   end

   riscv_hazardunit riscv_hazardunit_inst
   (
      .i_riscv_hzrdu_rs1addr_d   (dec_rs1),
      .i_riscv_hzrdu_rs2addr_d   (dec_rs2),
      .i_riscv_hzrdu_rs1addr_e   (de_q.rs1),
      .i_riscv_hzrdu_rs2addr_e   (de_q.rs2),
      .i_riscv_hzrdu_rdaddr_e    (de_q.rd),
      .i_riscv_hzrdu_rdaddr_m    (em_q.rd),
      .i_riscv_hzrdu_rdaddr_w    (mw_q.rd),
      .i_riscv_hzrdu_regw_m      (em_q.regwrite),
      .i_riscv_hzrdu_regw_w      (mw_q.regwrite),
      .i_riscv_hzrdu_pcsrc       (ex_pcsrc),
      .i_riscv_hzrdu_resultsrc_e (de_q.ctrl.res_src),
      .o_riscv_hzrdu_ctrl        (hz)
   );

   riscv_execute riscv_execute_inst
   (
      .i_de            (de_q),
      .i_fwda          (hz.fwda),
      .i_fwdb          (hz.fwdb),
      .i_fwd_m         (em_q.alu_result),
      .i_fwd_w         (mw_q.result),
      .o_alu_result    (ex_alu),
      .o_store_data    (ex_store),
      .o_branch_target (ex_target),
      .o_pcsrc         (ex_pcsrc)
   );

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         em_q.valid    <= 1'b0;
         em_q.regwrite <= 1'b0;
         em_q.memwrite <= 1'b0;
      end
      else
      begin
         em_q.valid      <= de_q.valid;
         em_q.regwrite   <= de_q.valid && de_q.ctrl.regwrite;
         em_q.memwrite   <= de_q.valid && de_q.ctrl.memwrite;
         em_q.res_src    <= de_q.ctrl.res_src;
         em_q.rd         <= de_q.rd;
         em_q.alu_result <= ex_alu;
         em_q.store_data <= ex_store;
         em_q.pc4        <= de_q.pc + 'd4;   // jal link value
      end
   end

   riscv_dmem riscv_dmem_inst
   (
      .i_clk     (i_clk),
      .i_wr_en   (em_q.memwrite),
      .i_addr    (em_q.alu_result),
      .i_wr_data (em_q.store_data),
      .o_rd_data (mem_rdata)
   );

   always_comb
   begin
      case (em_q.res_src)
         riscv_isa_pkg::MEM: wb_result = mem_rdata;
         riscv_isa_pkg::PC4: wb_result = em_q.pc4;
         default:            wb_result = em_q.alu_result;
      endcase
   end

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         mw_q.valid    <= 1'b0;
         mw_q.regwrite <= 1'b0;
      end
      else
      begin
         mw_q.valid    <= em_q.valid;
         mw_q.regwrite <= em_q.regwrite;
         mw_q.rd       <= em_q.rd;
         mw_q.result   <= wb_result;
      end
   end

   // every register write shows up here, x0 included
   assign o_retire.valid = mw_q.valid && mw_q.regwrite;
   assign o_retire.rd    = mw_q.rd;
   assign o_retire.data  = mw_q.result;

endmodule

// File: verification/riscv_clkgen.sv
`timescale 1ns/1ps

module riscv_clkgen
#(
   parameter realtime half_period = 50ns   // 100 ns clock
)
(
   output logic o_clk
);

   initial
   begin
      o_clk = 1'b0;
   end

   always #(half_period) o_clk = ~o_clk;   // free running

endmodule

// File: verification/riscv_core_tb.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_core_tb;

   localparam int max_cycles = 2000;   // five tests near 100 cycles each incl reset, x4
   localparam logic [31:0] nop_word = 32'h0000_0013;   // addi x0, x0, 0

   logic                    clk;
   logic                    rst_n;
   logic [`RISCV_XLEN-1:0]  imem_addr;
   logic [`RISCV_XLEN-1:0]  imem_rdata;
   riscv_pipe_pkg::retire_t retire;

   logic [31:0] prog [64];   // program of the running test
   int          prog_len = 0;
   riscv_pipe_pkg::retire_t exp_q [$];   // predicted retire stream

   int          error_count = 0;
   int          pass_count = 0;
   int          fail_count = 0;
   int          cycle_count = 0;
   int unsigned lcg_state = 90216;

   riscv_clkgen riscv_clkgen_inst
   (
      .o_clk (clk)
   );

   riscv_core riscv_core_inst
   (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .o_imem_addr  (imem_addr),
      .i_imem_rdata (imem_rdata),
      .o_retire     (retire)
   );

   // instruction encoders, plain rv32i field layout
   function automatic logic [31:0] addi(int rd, int rs1, int imm);
      return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
   endfunction

   function automatic logic [31:0] alu_rr(string m, int rd, int rs1, int rs2);
      logic [2:0] f3;
      logic [6:0] f7;
      f3 = 3'b000;
      f7 = 7'b0000000;
      if (m == "sub")
         f7 = 7'b0100000;
      else if (m == "slt")
         f3 = 3'b010;
      else if (m == "xor")
         f3 = 3'b100;
      else if (m == "or")
         f3 = 3'b110;
      else if (m == "and")
         f3 = 3'b111;
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
   endfunction

   function automatic logic [31:0] lw(int rd, int rs1, int off);
      return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
   endfunction

   function automatic logic [31:0] sw(int rs2, int rs1, int off);
      return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] cond_branch(bit ne, int rs1, int rs2, int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, ne, off[4:1], off[11],
              7'b1100011};
   endfunction

   function automatic logic [31:0] jal(int rd, int off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
   endfunction

   function automatic void emit(logic [31:0] w);
      prog[prog_len] = w;
      prog_len++;
   endfunction

   function automatic logic [31:0] fetch_word(logic [31:0] addr);
      int idx;
      idx = int'(addr[31:2]);
      if (idx < prog_len)
         return prog[idx];
      return nop_word;   // past the end of the program
   endfunction

   function automatic int unsigned next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int random_below(int n);
      int unsigned v;
      v = next_random();
      return int'((v >> 8) % n);   // low lcg bits are weak
   endfunction

   task automatic compare_value(string what, logic [31:0] expected, logic [31:0] actual);
      if (expected !== actual)
      begin
         error_count++;
         $display("Error %s expected 0x%08h actual 0x%08h", what, expected, actual);
      end
   endtask

   // in-order ISA model, fills exp_q with every register write
   task automatic run_model();
      logic [31:0] ref_regs [32];
      logic [31:0] ref_mem [256];
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] addr;
      logic [31:0] val;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] imm_b;
      logic [31:0] imm_j;
      logic        wr;
      int          pc;
      int          next_pc;
      int          steps;
      riscv_pipe_pkg::retire_t rec;
      exp_q.delete();
      for (int k = 0; k < 32; k++)
         ref_regs[k] = '0;
      for (int k = 0; k < 256; k++)
         ref_mem[k] = '0;
      pc = 0;
      steps = 0;
      while (pc / 4 < prog_len && steps < 256)
      begin
         w     = prog[pc / 4];
         a     = ref_regs[w[19:15]];
         b     = ref_regs[w[24:20]];
         imm_i = {{20{w[31]}}, w[31:20]};
         imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
         imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         wr    = 1'b0;
         val   = '0;
         next_pc = pc + 4;
         case (w[6:0])
            7'b0110011:   // register ops
            begin
               wr = 1'b1;
               case (w[14:12])
                  3'b000:  val = w[30] ? a - b : a + b;
                  3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  3'b100:  val = a ^ b;
                  3'b110:  val = a | b;
                  default: val = a & b;
               endcase
            end
            7'b0010011:
            begin
               wr  = 1'b1;
               val = a + imm_i;
            end
            7'b0000011:
            begin
               wr   = 1'b1;
               addr = a + imm_i;
               val  = ref_mem[addr[9:2]];
            end
            7'b0100011:
            begin
               addr = a + imm_s;
               ref_mem[addr[9:2]] = b;
            end
            7'b1100011:   // beq when funct3[0] is clear, bne when set
            begin
               if ((a == b) ^ w[12])
                  next_pc = pc + int'(imm_b);
            end
            7'b1101111:
            begin
               wr  = 1'b1;
               val = 32'(pc + 4);   // link
               next_pc = pc + int'(imm_j);
            end
            default:
            begin
               wr = 1'b0;
            end
         endcase
         if (wr)
         begin
            rec.valid = 1'b1;
            rec.rd    = w[11:7];
            rec.data  = val;   // x0 writes still retire their value
            exp_q.push_back(rec);
            if (w[11:7] != 5'd0)
               ref_regs[w[11:7]] = val;
         end
         pc = next_pc;
         steps++;
      end
   endtask

   task automatic reset_core();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
   endtask

   // match retires against exp_q in order, then look for strays
   task automatic collect_retires(string name);
      int got;
      int waited;
      int extra;
      int limit;
      riscv_pipe_pkg::retire_t rec;
      got    = 0;
      waited = 0;
      extra  = 0;
      limit  = 4 * prog_len + 30;
      while (got < exp_q.size() && waited < limit)
      begin
         @(negedge clk);
         waited++;
         if (retire.valid)
         begin
            rec = exp_q[got];
            compare_value($sformatf("%s retire %0d rd", name, got), 32'(rec.rd), 32'(retire.rd));
            compare_value($sformatf("%s retire %0d data", name, got), rec.data, retire.data);
            got++;
         end
      end
      if (got < exp_q.size())
      begin
         error_count++;
         $display("%s: only %0d of %0d expected retires arrived", name, got, exp_q.size());
      end
      repeat (8)
      begin
         @(negedge clk);
         if (retire.valid && (retire.rd != '0 || retire.data != '0))
            extra++;   // trailing nops retire as x0 <- 0
      end
      if (extra > 0)
      begin
         error_count++;
         $display("%s: %0d unexpected retires after the program ended", name, extra);
      end
   endtask

   task automatic report_test(string name, int errs_before);
      if (error_count == errs_before)
      begin
         pass_count++;
         $display("%s: passed", name);
      end
      else
      begin
         fail_count++;
         $display("%s: failed with %0d errors", name, error_count - errs_before);
      end
   endtask

   task automatic check_reset();
      int errs_before;
      errs_before = error_count;
      prog_len = 0;
      emit(addi(1, 0, 1));
      emit(addi(2, 1, 2));
      emit(addi(3, 2, 3));
      emit(alu_rr("add", 4, 3, 1));
      run_model();
      reset_core();
      for (int k = 0; k < 4; k++)
      begin
         if (k > 0)
            @(negedge clk);
         compare_value($sformatf("reset fetch address cycle %0d", k), 32'(4 * k), imem_addr);
         compare_value($sformatf("reset retire cycle %0d", k), 32'd0, 32'(retire.valid));
      end
      collect_retires("reset");
      report_test("reset", errs_before);
   endtask

   task automatic forwarding_chain();
      int errs_before;
      errs_before = error_count;
      prog_len = 0;
      emit(addi(1, 0, 5));
      emit(addi(2, 1, 3));            // from memory stage
      emit(alu_rr("add", 3, 1, 2));   // rs1 from writeback, rs2 from memory
      emit(addi(1, 1, 10));
      emit(addi(1, 1, 1));
      emit(alu_rr("sub", 4, 1, 3));   // both stages hold x1, newer wins
      emit(addi(0, 0, 7));            // x0 write in flight
      emit(alu_rr("add", 5, 0, 4));   // must read zero
      emit(alu_rr("xor", 6, 5, 1));
      emit(alu_rr("or", 7, 6, 2));
      emit(alu_rr("and", 8, 7, 4));
      emit(alu_rr("slt", 9, 4, 1));
      emit(alu_rr("slt", 10, 1, 4));
      emit(addi(11, 0, -3));
      emit(alu_rr("slt", 12, 11, 0)); // signed, negative below zero
      run_model();
      reset_core();
      collect_retires("forwarding");
      report_test("forwarding", errs_before);
   endtask

   task automatic load_store();
      int errs_before;
      errs_before = error_count;
      prog_len = 0;
      emit(addi(1, 0, 64));           // base address
      emit(addi(2, 0, 123));
      emit(sw(2, 1, 0));              // store data forwarded
      emit(addi(3, 0, -7));
      emit(sw(3, 1, 4));
      emit(lw(4, 1, 0));
      emit(alu_rr("add", 5, 4, 4));   // load-use stall
      emit(lw(6, 1, 4));
      emit(addi(7, 6, 1));            // load-use again
      emit(sw(7, 1, 8));
      emit(lw(8, 1, 8));
      emit(alu_rr("sub", 9, 8, 5));
      run_model();
      reset_core();
      collect_retires("load_store");
      report_test("load_store", errs_before);
   endtask

   task automatic branch_and_jump();
      int errs_before;
      errs_before = error_count;
      prog_len = 0;
      emit(addi(1, 0, 1));                  // 0
      emit(addi(2, 0, 1));                  // 4
      emit(cond_branch(1'b0, 1, 2, 12));    // 8  beq taken to 20
      emit(addi(3, 0, 99));                 // 12 shadow
      emit(addi(4, 0, 99));                 // 16 shadow
      emit(cond_branch(1'b1, 1, 2, 8));     // 20 bne not taken
      emit(addi(5, 0, 5));                  // 24
      emit(cond_branch(1'b0, 1, 0, 8));     // 28 beq not taken
      emit(cond_branch(1'b1, 5, 0, 12));    // 32 bne taken to 44
      emit(addi(6, 0, 99));                 // 36 shadow
      emit(addi(7, 0, 99));                 // 40 shadow
      emit(jal(8, 12));                     // 44 to 56, x8 = 48
      emit(addi(9, 0, 99));                 // 48 shadow
      emit(addi(10, 0, 99));                // 52 shadow
      emit(alu_rr("add", 11, 8, 5));        // 56 link value forwarded
      emit(jal(0, 8));                      // 60 to 68, retires x0
      emit(addi(12, 0, 99));                // 64 shadow
      emit(addi(13, 11, 1));                // 68
      run_model();
      reset_core();
      collect_retires("control_flow");
      report_test("control_flow", errs_before);
   endtask

   task automatic random_alu();
      int errs_before;
      int op;
      int rd;
      int rs1;
      int rs2;
      int imm;
      errs_before = error_count;
      prog_len = 0;
      for (int i = 0; i < 40; i++)
      begin
         op  = random_below(7);
         rd  = random_below(8);   // small register set, many dependencies
         rs1 = random_below(8);
         rs2 = random_below(8);
         imm = random_below(4096) - 2048;
         case (op)
            0:       emit(alu_rr("add", rd, rs1, rs2));
            1:       emit(alu_rr("sub", rd, rs1, rs2));
            2:       emit(alu_rr("and", rd, rs1, rs2));
            3:       emit(alu_rr("or", rd, rs1, rs2));
            4:       emit(alu_rr("xor", rd, rs1, rs2));
            5:       emit(alu_rr("slt", rd, rs1, rs2));
            default: emit(addi(rd, rs1, imm));
         endcase
      end
      run_model();
      reset_core();
      collect_retires("random");
      report_test("random", errs_before);
   endtask

   // instruction memory answers the current pc, updated off the capture edge
   initial
   begin
      imem_rdata = nop_word;
      forever
      begin
         @(negedge clk);
         imem_rdata = fetch_word(imem_addr);
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= max_cycles)
      begin
         $display("Timeout: the run did not finish within %0d cycles", max_cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   initial
   begin
      rst_n = 1'b0;
      check_reset();
      forwarding_chain();
      load_store();
      branch_and_jump();
      random_alu();
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               pass_count + fail_count, pass_count, fail_count, error_count);
      if (error_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: riscv_core.f
+incdir+include
hw/riscv_isa_pkg.sv
hw/riscv_pipe_pkg.sv
hw/riscv_hazardunit.sv
hw/riscv_decode.sv
hw/riscv_regfile.sv
hw/riscv_execute.sv
hw/riscv_dmem.sv
hw/riscv_core.sv
verification/riscv_clkgen.sv
verification/riscv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f riscv_core.f --top-module riscv_core_tb -o riscv_core_sim \
   && ./obj_dir/riscv_core_sim > sim.log 2>&1 \
   || { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qxF '** PASS **' sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
